// File: design/beacon_report.sv
`timescale 1ns/1ps
`default_nettype none

// pass-through / beacon report merge, output credit metering
module beacon_report (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire lcm_pkg::flit_t  upd_flit,
	input  wire                  upd_valid,
	output logic                 upd_ready,
	input  wire lcm_pkg::time_t  precision_time,
	input  wire lcm_pkg::mac_t   local_mac,
	input  wire                  cfg_direction,
	input  wire lcm_pkg::tbpara_t cfg_tbpara,
	input  wire lcm_pkg::mac_t   cfg_direct_mac,
	input  wire lcm_pkg::cnt_t   esw_pktin_cnt,
	input  wire lcm_pkg::cnt_t   esw_pktout_cnt,
	input  wire lcm_pkg::qcnt_t  eos_q0_used_cnt,
	input  wire lcm_pkg::qcnt_t  eos_q1_used_cnt,
	input  wire lcm_pkg::qcnt_t  eos_q2_used_cnt,
	input  wire lcm_pkg::qcnt_t  eos_q3_used_cnt,
	input  wire lcm_pkg::cnt_t   goe_pktin_cnt,
	input  wire lcm_pkg::cnt_t   goe_discard_cnt,
	input  wire                  out_credit,
	output lcm_pkg::flit_t       out_flit,
	output logic                 out_flit_wr
);
	import lcm_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_PKT,
		ST_REPORT
	} state_t;

	state_t state;

	logic [$clog2(OUT_CREDITS+1)-1:0] credit_cnt;
	logic credit_ok;
	logic [$clog2(REPORT_FLITS)-1:0] rep_idx;
	flit_t report_flit;

	// rollover detection
	logic low_nz;
	logic prev_nz;
	logic rollover;
	// report due, waiting for a packet boundary
	logic pending;
	// time at the last rollover, and the copy the running report uses
	time_t ts_cap;
	time_t ts_rep;

	logic pass_take;
	logic rep_emit;
	logic send;
	tag_t pass_tag;

	//**************************************************************************
	// period tracking
	//**************************************************************************
	assign low_nz = |precision_time[REPORT_PERIOD_BITS-1:0];
	// low bits just wrapped to zero
	assign rollover = prev_nz && !low_nz;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prev_nz <= 1'b0;
		end else begin
			prev_nz <= low_nz;
		end
	end

	always_ff @(posedge clk) begin
		if (rollover) begin
			ts_cap <= precision_time;
		end
		if (state == ST_IDLE && pending) begin
			ts_rep <= ts_cap;
		end
	end

	//**************************************************************************
	// stream selection
	//**************************************************************************
	assign credit_ok = (credit_cnt != '0);
	assign pass_tag = flit_tag(upd_flit);

	// a pending report wins at the boundary, the packet runs to its tail
	always_comb begin
		case (state)
			ST_IDLE: upd_ready = credit_ok && !pending;
			ST_PKT: upd_ready = credit_ok;
			default: upd_ready = 1'b0;
		endcase
	end

	assign pass_take = upd_valid && upd_ready;
	assign rep_emit = (state == ST_REPORT) && credit_ok;
	assign send = pass_take || rep_emit;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			pending <= 1'b0;
			rep_idx <= '0;
		end else begin
			// a new due always sticks, even during a report
			if (rollover) begin
				pending <= 1'b1;
			end else if (state == ST_IDLE && pending) begin
				pending <= 1'b0;
			end
			case (state)
				ST_IDLE: begin
					if (pending) begin
						state <= ST_REPORT;
						rep_idx <= '0;
					end else if (pass_take && pass_tag == TAG_HEAD) begin
						state <= ST_PKT;
					end
				end
				ST_PKT: begin
					if (pass_take && pass_tag == TAG_TAIL) begin
						state <= ST_IDLE;
					end
				end
				ST_REPORT: begin
					// stalls in place with no credit
					if (rep_emit) begin
						rep_idx <= rep_idx + 1'b1;
						if (rep_idx == REPORT_FLITS - 1) begin
							state <= ST_IDLE;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	//**************************************************************************
	// report content
	//**************************************************************************
	always_comb begin
		case (rep_idx)
			// header to the controller
			3'd0: report_flit = make_flit(TAG_HEAD, {CNC_MAC, local_mac,
				ETH_TYPE_SYNC, 4'h0, MSG_REPORT, 8'h00});
			3'd1: report_flit = make_flit(TAG_MID, {ts_rep, 80'h0});
			// beacon configuration
			3'd2: report_flit = make_flit(TAG_MID, {cfg_direct_mac, cfg_direction,
				15'h0, cfg_tbpara, 32'h0});
			3'd3: report_flit = make_flit(TAG_MID, {esw_pktin_cnt, esw_pktout_cnt});
			// queue occupancy, top 24 bits
			3'd4: report_flit = make_flit(TAG_MID, {eos_q0_used_cnt, eos_q1_used_cnt,
				eos_q2_used_cnt, eos_q3_used_cnt, 104'h0});
			default: report_flit = make_flit(TAG_TAIL, {goe_pktin_cnt, goe_discard_cnt});
		endcase
	end

	//**************************************************************************
	// output register and credits
	//**************************************************************************
	always_ff @(posedge clk) begin
		if (send) begin
			out_flit <= pass_take ? upd_flit : report_flit;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_flit_wr <= 1'b0;
		end else begin
			out_flit_wr <= send;
		end
	end

	// send and returned credit together cancel out
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			credit_cnt <= $bits(credit_cnt)'(OUT_CREDITS);
		end else begin
			case ({send, out_credit})
				2'b10: credit_cnt <= credit_cnt - 1'b1;
				2'b01: credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	// downstream never returns more than it was given
	a_credit_max: assert property (
		@(posedge clk) disable iff (!rst_n)
		credit_cnt <= OUT_CREDITS
	) else $error("beacon_report: output credit count above OUT_CREDITS");

endmodule

`default_nettype wire

// File: design/beacon_update.sv
`timescale 1ns/1ps
`default_nettype none

// beacon update filter and configuration registers
module beacon_update (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire lcm_pkg::flit_t  fifo_flit,
	input  wire                  fifo_valid,
	input  wire lcm_pkg::mac_t   local_mac,
	output logic                 fifo_ready,
	output lcm_pkg::flit_t       upd_flit,
	output logic                 upd_valid,
	input  wire                  upd_ready,
	output logic                 cfg_direction,
	output lcm_pkg::tbpara_t     cfg_tbpara,
	output lcm_pkg::mac_t        cfg_direct_mac
);
	import lcm_pkg::*;

	tag_t in_tag;
	logic is_upd_head;
	logic take;
	logic drop;
	logic pass;
	// inside a consumed update packet, after its head
	logic drop_act;
	// next dropped flit carries the configuration
	logic cfg_next;
	// last flit taken was a tail
	logic last_tail;

	assign in_tag = flit_tag(fifo_flit);

	// head payload: dst mac 127:80, eth type 31:16, msg type 11:8
	assign is_upd_head = fifo_valid && (in_tag == TAG_HEAD) &&
		(fifo_flit[127:80] == local_mac) &&
		(fifo_flit[31:16] == ETH_TYPE_SYNC) &&
		(fifo_flit[11:8] == MSG_UPDATE);

	// update packets are swallowed whole, never wait on the output
	assign fifo_ready = drop_act || is_upd_head || !upd_valid || upd_ready;
	assign take = fifo_valid && fifo_ready;
	assign drop = take && (drop_act || is_upd_head);
	assign pass = take && !drop;

	// one entry output register
	always_ff @(posedge clk) begin
		if (pass) begin
			upd_flit <= fifo_flit;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			upd_valid <= 1'b0;
		end else if (pass) begin
			upd_valid <= 1'b1;
		end else if (upd_ready) begin
			upd_valid <= 1'b0;
		end
	end

	// update packet tracking
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			drop_act <= 1'b0;
			cfg_next <= 1'b0;
			last_tail <= 1'b1;
		end else if (take) begin
			last_tail <= (in_tag == TAG_TAIL);
			if (is_upd_head && !drop_act) begin
				drop_act <= 1'b1;
				cfg_next <= 1'b1;
			end else if (drop_act) begin
				cfg_next <= 1'b0;
				if (in_tag == TAG_TAIL) begin
					drop_act <= 1'b0;
				end
			end
		end
	end

	// config flit: direct mac 127:80, direction 79, tb para 63:32
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg_direction <= CFG_DIRECTION_RST;
			cfg_tbpara <= CFG_TBPARA_RST;
			cfg_direct_mac <= CFG_DIRECT_MAC_RST;
		end else if (drop && drop_act && cfg_next) begin
			cfg_direction <= fifo_flit[79];
			cfg_tbpara <= fifo_flit[63:32];
			cfg_direct_mac <= fifo_flit[127:80];
		end
	end

	// packets from the engine never interleave
	a_head_after_tail: assert property (
		@(posedge clk) disable iff (!rst_n)
		(take && in_tag == TAG_HEAD) |-> last_tail
	) else $error("beacon_update: head flit inside an open packet");

endmodule

`default_nettype wire

// File: design/flit_fifo.sv
`timescale 1ns/1ps
`default_nettype none

// input flit buffer, one credit back upstream per pop
module flit_fifo (
	input  wire                 clk,
	input  wire                 rst_n,
	input  wire lcm_pkg::flit_t in_flit,
	input  wire                 in_flit_wr,
	output logic                in_credit,
	output lcm_pkg::flit_t      fifo_flit,
	output logic                fifo_valid,
	input  wire                 fifo_ready
);
	import lcm_pkg::*;

	// storage, payload only so no reset
	flit_t mem [FIFO_DEPTH];

	logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
	logic [$clog2(FIFO_DEPTH+1)-1:0] count;
	logic push;
	logic pop;

	assign push = in_flit_wr && (count != FIFO_DEPTH);
	assign pop = fifo_valid && fifo_ready;

	// head of buffer visible the cycle after its write
	assign fifo_valid = (count != '0);
	assign fifo_flit = mem[rd_ptr];

	// credit goes back as the slot frees
	assign in_credit = pop;

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_flit;
		end
	end

	// pointers wrap on the power of two depth
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// upstream must hold a credit for every write
	a_no_write_when_full: assert property (
		@(posedge clk) disable iff (!rst_n)
		in_flit_wr |-> (count != FIFO_DEPTH)
	) else $error("flit_fifo: write while full, upstream credit violation");

endmodule

`default_nettype wire

// File: design/lcm_pkg.sv
`default_nettype none

//**************************************************************************
// shared types and constants of the local control block
//**************************************************************************
package lcm_pkg;

	// widths with a meaning
	typedef logic [133:0] flit_t;
	typedef logic [1:0]   tag_t;
	typedef logic [47:0]  mac_t;
	// precision time in microseconds
	typedef logic [47:0]  time_t;
	typedef logic [63:0]  cnt_t;
	typedef logic [5:0]   qcnt_t;
	typedef logic [31:0]  tbpara_t;

	// flit position tags
	localparam tag_t TAG_HEAD = 2'b01;
	localparam tag_t TAG_MID  = 2'b11;
	localparam tag_t TAG_TAIL = 2'b10;

	// sync message header fields
	localparam logic [15:0] ETH_TYPE_SYNC = 16'h88f7;
	localparam logic [3:0]  MSG_REPORT    = 4'he;
	localparam logic [3:0]  MSG_UPDATE    = 4'hf;
	// central controller address, destination of every report
	localparam mac_t        CNC_MAC       = 48'h0102_0304_0506;

	// sizes
	localparam int REPORT_PERIOD_BITS = 20;
	localparam int REPORT_FLITS       = 6;
	// buffer depth equals the upstream credit count
	localparam int FIFO_DEPTH         = 8;
	localparam int OUT_CREDITS        = 4;

	// beacon configuration after reset
	localparam logic    CFG_DIRECTION_RST  = 1'b0;
	localparam tbpara_t CFG_TBPARA_RST     = 32'h0000_0000;
	localparam mac_t    CFG_DIRECT_MAC_RST = 48'h0000_0000_0000;

	// tag sits in bits 133:132
	function automatic tag_t flit_tag(input flit_t f);
		return f[133:132];
	endfunction

	// flit with zero invalid bytes, count in 131:128
	function automatic flit_t make_flit(input tag_t tag, input logic [127:0] payload);
		return {tag, 4'h0, payload};
	endfunction

endpackage

`default_nettype wire

// File: design/lcm_top.sv
`timescale 1ns/1ps
`default_nettype none

// local control block: input buffer, update filter, report merge
module lcm_top (
	input  wire                   clk,
	input  wire                   rst_n,
	// upstream, credit based
	input  wire lcm_pkg::flit_t   in_flit,
	input  wire                   in_flit_wr,
	output wire                   in_credit,
	// downstream, credit based
	output wire lcm_pkg::flit_t   out_flit,
	output wire                   out_flit_wr,
	input  wire                   out_credit,
	input  wire lcm_pkg::time_t   precision_time,
	input  wire lcm_pkg::mac_t    local_mac,
	// statistics for the report
	input  wire lcm_pkg::cnt_t    esw_pktin_cnt,
	input  wire lcm_pkg::cnt_t    esw_pktout_cnt,
	input  wire lcm_pkg::qcnt_t   eos_q0_used_cnt,
	input  wire lcm_pkg::qcnt_t   eos_q1_used_cnt,
	input  wire lcm_pkg::qcnt_t   eos_q2_used_cnt,
	input  wire lcm_pkg::qcnt_t   eos_q3_used_cnt,
	input  wire lcm_pkg::cnt_t    goe_pktin_cnt,
	input  wire lcm_pkg::cnt_t    goe_discard_cnt,
	// beacon configuration
	output wire                   cfg_direction,
	output wire lcm_pkg::tbpara_t cfg_tbpara,
	output wire lcm_pkg::mac_t    cfg_direct_mac
);
	import lcm_pkg::*;

	// fifo to update filter
	wire flit_t fifo_flit;
	wire fifo_valid;
	wire fifo_ready;
	// update filter to report merge
	wire flit_t upd_flit;
	wire upd_valid;
	wire upd_ready;

	flit_fifo fifo_i (
		.clk(clk),
		.rst_n(rst_n),
		.in_flit(in_flit),
		.in_flit_wr(in_flit_wr),
		.in_credit(in_credit),
		.fifo_flit(fifo_flit),
		.fifo_valid(fifo_valid),
		.fifo_ready(fifo_ready)
	);

	beacon_update update_i (
		.clk(clk),
		.rst_n(rst_n),
		.fifo_flit(fifo_flit),
		.fifo_valid(fifo_valid),
		.local_mac(local_mac),
		.fifo_ready(fifo_ready),
		.upd_flit(upd_flit),
		.upd_valid(upd_valid),
		.upd_ready(upd_ready),
		.cfg_direction(cfg_direction),
		.cfg_tbpara(cfg_tbpara),
		.cfg_direct_mac(cfg_direct_mac)
	);

	beacon_report report_i (
		.clk(clk),
		.rst_n(rst_n),
		.upd_flit(upd_flit),
		.upd_valid(upd_valid),
		.upd_ready(upd_ready),
		.precision_time(precision_time),
		.local_mac(local_mac),
		.cfg_direction(cfg_direction),
		.cfg_tbpara(cfg_tbpara),
		.cfg_direct_mac(cfg_direct_mac),
		.esw_pktin_cnt(esw_pktin_cnt),
		.esw_pktout_cnt(esw_pktout_cnt),
		.eos_q0_used_cnt(eos_q0_used_cnt),
		.eos_q1_used_cnt(eos_q1_used_cnt),
		.eos_q2_used_cnt(eos_q2_used_cnt),
		.eos_q3_used_cnt(eos_q3_used_cnt),
		.goe_pktin_cnt(goe_pktin_cnt),
		.goe_discard_cnt(goe_discard_cnt),
		.out_credit(out_credit),
		.out_flit(out_flit),
		.out_flit_wr(out_flit_wr)
	);

endmodule

`default_nettype wire

// File: dv/lcm_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lcm_tb;
	import lcm_pkg::*;

	localparam int WAIT_LIMIT = 5000;
	localparam int NUM_RANDOM_PKTS = 40;

	logic clk;
	logic rst_n;
	flit_t in_flit;
	logic in_flit_wr;
	wire in_credit;
	wire flit_t out_flit;
	wire out_flit_wr;
	logic out_credit;
	time_t precision_time;
	mac_t local_mac;
	cnt_t esw_pktin_cnt;
	cnt_t esw_pktout_cnt;
	qcnt_t eos_q0_used_cnt;
	qcnt_t eos_q1_used_cnt;
	qcnt_t eos_q2_used_cnt;
	qcnt_t eos_q3_used_cnt;
	cnt_t goe_pktin_cnt;
	cnt_t goe_discard_cnt;
	wire cfg_direction;
	wire tbpara_t cfg_tbpara;
	wire mac_t cfg_direct_mac;

	integer seed;
	// waiting for the upstream driver
	flit_t tx_q[$];
	// expected at out_flit, in order
	flit_t exp_q[$];
	// scratch packet
	flit_t pkt_q[$];
	flit_t exp_f;
	// upstream and downstream credit bookkeeping
	int up_credits;
	int ds_held;
	int wr_total;
	int credit_total;
	int heads_out;
	// time model
	logic jump_req;
	time_t jump_val;
	time_t roll_ts;
	int roll_cnt;
	// configuration the DUT should hold
	logic exp_dir;
	tbpara_t exp_tbpara;
	mac_t exp_dmac;

	lcm_top dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.in_flit(in_flit),
		.in_flit_wr(in_flit_wr),
		.in_credit(in_credit),
		.out_flit(out_flit),
		.out_flit_wr(out_flit_wr),
		.out_credit(out_credit),
		.precision_time(precision_time),
		.local_mac(local_mac),
		.esw_pktin_cnt(esw_pktin_cnt),
		.esw_pktout_cnt(esw_pktout_cnt),
		.eos_q0_used_cnt(eos_q0_used_cnt),
		.eos_q1_used_cnt(eos_q1_used_cnt),
		.eos_q2_used_cnt(eos_q2_used_cnt),
		.eos_q3_used_cnt(eos_q3_used_cnt),
		.goe_pktin_cnt(goe_pktin_cnt),
		.goe_discard_cnt(goe_discard_cnt),
		.cfg_direction(cfg_direction),
		.cfg_tbpara(cfg_tbpara),
		.cfg_direct_mac(cfg_direct_mac)
	);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	//**************************************************************************
	// checks and reference
	//**************************************************************************
	task automatic fail_stop(input string msg);
		$display("%s, at %0t ns", msg, $time);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic check_flit(input flit_t exp, input flit_t act);
		if (act !== exp) begin
			$display("** Error @ %0t ns: out_flit expected %h, actual %h", $time, exp, act);
			$display("*** FAILED ***");
			$fatal(1);
		end
	endtask

	task automatic check_cfg(input tbpara_t tb, input mac_t dmac, input logic dir);
		if (cfg_tbpara !== tb || cfg_direct_mac !== dmac || cfg_direction !== dir) begin
			$display("** Error @ %0t ns: config expected %h/%h/%b, actual %h/%h/%b",
				$time, tb, dmac, dir, cfg_tbpara, cfg_direct_mac, cfg_direction);
			$display("*** FAILED ***");
			$fatal(1);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("** Error @ %0t ns: %s expected %b, actual %b", $time, name, exp, act);
			$display("*** FAILED ***");
			$fatal(1);
		end
	endtask

	// report flit idx, built from the stimulus and the tb time model
	function automatic flit_t expected_report(input int idx, input time_t ts);
		logic [127:0] p;
		tag_t tag;
		tag = TAG_MID;
		case (idx)
			0: begin
				tag = TAG_HEAD;
				p = {CNC_MAC, local_mac, ETH_TYPE_SYNC, 4'h0, MSG_REPORT, 8'h00};
			end
			1: p = {ts, 80'h0};
			2: p = {exp_dmac, exp_dir, 15'h0, exp_tbpara, 32'h0};
			3: p = {esw_pktin_cnt, esw_pktout_cnt};
			// queue counts in the top 24 bits
			4: p = {eos_q0_used_cnt, eos_q1_used_cnt, eos_q2_used_cnt, eos_q3_used_cnt,
				104'h0};
			default: begin
				tag = TAG_TAIL;
				p = {goe_pktin_cnt, goe_discard_cnt};
			end
		endcase
		return {tag, 4'h0, p};
	endfunction

	//**************************************************************************
	// stimulus helpers
	//**************************************************************************
	task automatic build_packet(input int len);
		int k;
		logic [127:0] p;
		logic [31:0] r;
		pkt_q.delete();
		for (k = 0; k < len; k++) begin
			p = {$random(seed), $random(seed), $random(seed), $random(seed)};
			if (k == 0) begin
				// ip ethertype, never taken for an update
				p[31:16] = 16'h0800;
				pkt_q.push_back({TAG_HEAD, 4'h0, p});
			end else if (k == len - 1) begin
				r = $random(seed);
				pkt_q.push_back({TAG_TAIL, r[3:0], p});
			end else begin
				pkt_q.push_back({TAG_MID, 4'h0, p});
			end
		end
	endtask

	// head, config flit, empty tail
	task automatic build_update(input mac_t dst, input logic dir, input tbpara_t tb,
		input mac_t dmac);
		pkt_q.delete();
		pkt_q.push_back({TAG_HEAD, 4'h0, dst, CNC_MAC, ETH_TYPE_SYNC, 4'h0, MSG_UPDATE,
			8'h00});
		pkt_q.push_back({TAG_MID, 4'h0, dmac, dir, 15'h0, tb, 32'h0});
		pkt_q.push_back({TAG_TAIL, 4'h0, 128'h0});
	endtask

	task automatic queue_tx(input int lo, input int hi);
		int k;
		for (k = lo; k <= hi; k++) begin
			tx_q.push_back(pkt_q[k]);
		end
	endtask

	task automatic queue_exp(input int lo, input int hi);
		int k;
		for (k = lo; k <= hi; k++) begin
			exp_q.push_back(pkt_q[k]);
		end
	endtask

	task automatic queue_report();
		int k;
		for (k = 0; k < REPORT_FLITS; k++) begin
			exp_q.push_back(expected_report(k, roll_ts));
		end
	endtask

	// new statistics, applied on a falling edge
	task automatic set_stats();
		cnt_t v[4];
		logic [31:0] r;
		int k;
		for (k = 0; k < 4; k++) begin
			v[k] = {$random(seed), $random(seed)};
		end
		r = $random(seed);
		@(negedge clk);
		esw_pktin_cnt = v[0];
		esw_pktout_cnt = v[1];
		goe_pktin_cnt = v[2];
		goe_discard_cnt = v[3];
		eos_q0_used_cnt = r[5:0];
		eos_q1_used_cnt = r[11:6];
		eos_q2_used_cnt = r[17:12];
		eos_q3_used_cnt = r[23:18];
		@(posedge clk);
	endtask

	// low bits wrap four cycles after the jump
	task automatic trigger_rollover();
		jump_val = {precision_time[47:20] + 28'd16, 20'hffffc};
		jump_req = 1'b1;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (tx_q.size() != 0 || exp_q.size() != 0 || ds_held != 0) begin
			if (n == WAIT_LIMIT) begin
				fail_stop("traffic did not drain in time");
			end else begin
				n++;
				@(posedge clk);
			end
		end
	endtask

	task automatic wait_rollover(input int prev);
		int n;
		n = 0;
		while (roll_cnt == prev) begin
			if (n == WAIT_LIMIT) begin
				fail_stop("time rollover never happened");
			end else begin
				n++;
				@(posedge clk);
			end
		end
	endtask

	task automatic wait_head_out(input int prev);
		int n;
		n = 0;
		while (heads_out == prev) begin
			if (n == WAIT_LIMIT) begin
				fail_stop("head flit never reached out_flit");
			end else begin
				n++;
				@(posedge clk);
			end
		end
	endtask

	//**************************************************************************
	// falling edge drivers
	//**************************************************************************
	// upstream on its own credits, random credit return downstream
	always @(negedge clk) begin
		if (rst_n) begin
			in_flit_wr = 1'b0;
			out_credit = 1'b0;
			if (tx_q.size() > 0 && up_credits > 0 && ($random(seed) & 3) != 0) begin
				in_flit = tx_q.pop_front();
				in_flit_wr = 1'b1;
				up_credits--;
				wr_total++;
			end
			if (ds_held > 0 && ($random(seed) & 3) == 0) begin
				out_credit = 1'b1;
				ds_held--;
			end
		end
	end

	// microsecond counter with jumps toward a rollover
	always @(negedge clk) begin
		if (jump_req) begin
			precision_time = jump_val;
			jump_req = 1'b0;
		end else begin
			precision_time = precision_time + 1'b1;
		end
		if (precision_time[REPORT_PERIOD_BITS-1:0] == '0) begin
			roll_ts = precision_time;
			roll_cnt++;
		end
	end

	// credit accounting and output compare
	always @(posedge clk) begin
		if (rst_n) begin
			if (in_credit) begin
				up_credits++;
				credit_total++;
			end
			if (up_credits > FIFO_DEPTH) begin
				fail_stop("more upstream credits returned than flits written");
			end
			if (out_flit_wr) begin
				ds_held++;
				if (ds_held > OUT_CREDITS) begin
					fail_stop("downstream outstanding flits exceed OUT_CREDITS");
				end else if (exp_q.size() == 0) begin
					fail_stop("flit appeared at out_flit with none expected");
				end else begin
					exp_f = exp_q.pop_front();
					check_flit(exp_f, out_flit);
					if (out_flit[133:132] == TAG_HEAD) begin
						heads_out++;
					end
				end
			end
		end
	end

	//**************************************************************************
	// test sequence
	//**************************************************************************
	initial begin : main_seq
		int i;
		int len;
		int prev;
		seed = 32'h4e1c4217;
		rst_n = 1'b0;
		in_flit = '0;
		in_flit_wr = 1'b0;
		out_credit = 1'b0;
		precision_time = '0;
		local_mac = 48'h0a0b_0c0d_0e0f;
		esw_pktin_cnt = '0;
		esw_pktout_cnt = '0;
		eos_q0_used_cnt = '0;
		eos_q1_used_cnt = '0;
		eos_q2_used_cnt = '0;
		eos_q3_used_cnt = '0;
		goe_pktin_cnt = '0;
		goe_discard_cnt = '0;
		up_credits = FIFO_DEPTH;
		ds_held = 0;
		wr_total = 0;
		credit_total = 0;
		heads_out = 0;
		jump_req = 1'b0;
		jump_val = '0;
		roll_ts = '0;
		roll_cnt = 0;
		exp_dir = CFG_DIRECTION_RST;
		exp_tbpara = CFG_TBPARA_RST;
		exp_dmac = CFG_DIRECT_MAC_RST;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(posedge clk);
		check_flag("in_credit", 1'b0, in_credit);
		check_flag("out_flit_wr", 1'b0, out_flit_wr);
		check_cfg(exp_tbpara, exp_dmac, exp_dir);

		// plain packets pass in order
		for (i = 0; i < 12; i++) begin
			len = 2 + ($random(seed) & 7);
			build_packet(len);
			queue_tx(0, len - 1);
			queue_exp(0, len - 1);
		end
		wait_drain();

		// update for this node, swallowed
		exp_dir = 1'b1;
		exp_tbpara = $random(seed);
		exp_dmac = 48'({$random(seed), $random(seed)});
		build_update(local_mac, exp_dir, exp_tbpara, exp_dmac);
		queue_tx(0, 2);
		wait_drain();
		wait_cycles(2);
		check_cfg(exp_tbpara, exp_dmac, exp_dir);
		// update for another node, forwarded
		build_update(local_mac ^ 48'h1, 1'b0, ~exp_tbpara, ~exp_dmac);
		queue_tx(0, 2);
		queue_exp(0, 2);
		wait_drain();
		wait_cycles(2);
		check_cfg(exp_tbpara, exp_dmac, exp_dir);

		// rollover while idle, one report only
		set_stats();
		prev = roll_cnt;
		trigger_rollover();
		wait_rollover(prev);
		queue_report();
		wait_drain();
		wait_cycles(20);

		// rollover inside a packet, report after its tail
		set_stats();
		build_packet(8);
		prev = heads_out;
		queue_tx(0, 2);
		queue_exp(0, 7);
		wait_head_out(prev);
		prev = roll_cnt;
		trigger_rollover();
		wait_rollover(prev);
		queue_report();
		queue_tx(3, 7);
		wait_drain();

		// heavy traffic against random credit return
		for (i = 0; i < NUM_RANDOM_PKTS; i++) begin
			len = 2 + ($random(seed) & 7);
			build_packet(len);
			queue_tx(0, len - 1);
			queue_exp(0, len - 1);
		end
		wait_drain();
		wait_cycles(4);

		if (credit_total != wr_total || up_credits != FIFO_DEPTH) begin
			$display("upstream credits returned %0d, flits written %0d", credit_total,
				wr_total);
			$display("*** FAILED ***");
			$fatal(1);
		end else begin
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: files.f
design/lcm_pkg.sv
design/flit_fifo.sv
design/beacon_update.sv
design/beacon_report.sv
design/lcm_top.sv
dv/lcm_tb.sv
